// ==== logic/csr_consts.svh ====
/*
  widths, status bit positions and status mask for the supervisor CSR file
  only the S, PS, EI and PEI status bits are implemented, all others read zero
*/
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// datapath widths
`define CSR_WIDTH          64
`define CSR_ADDR_WIDTH     12
`define CAUSE_WIDTH        4
`define COMMIT_CNT_WIDTH   3

// status bit positions
`define SR_S_BIT           0
`define SR_PS_BIT          1
`define SR_EI_BIT          2
`define SR_PEI_BIT         3

// writable status bits and value after reset (supervisor mode)
`define CSR_STATUS_WR_MASK 64'h0000_0000_0000_000f
`define CSR_STATUS_RESET   64'h0000_0000_0000_0001

// fcsr layout, flags in the low bits and rounding mode above them
`define FFLAGS_WIDTH       5
`define FRM_LSB            5
`define FCSR_WIDTH         8

`endif

// ==== logic/csr_map_pkg.sv ====
/*
  architectural map of the kept CSRs and of the exception causes
  addresses outside csr_addr_e are unmapped and read as zero
*/
`include "csr_consts.svh"

package csr_map_pkg;

  // kept CSR addresses
  typedef enum logic [`CSR_ADDR_WIDTH-1:0] {
    CSR_FFLAGS   = 12'h001,
    CSR_FRM      = 12'h002,
    CSR_FCSR     = 12'h003,
    CSR_EVEC     = 12'h305,
    CSR_SUP0     = 12'h500,
    CSR_SUP1     = 12'h501,
    CSR_EPC      = 12'h502,
    CSR_BADVADDR = 12'h503,
    CSR_COUNT    = 12'h506,
    CSR_CAUSE    = 12'h509,
    CSR_STATUS   = 12'h50a
  } csr_addr_e;

  // causes that carry a faulting address
  // other cause codes are still legal on the wire
  typedef enum logic [`CAUSE_WIDTH-1:0] {
    EXC_MISALIGNED_FETCH = 4'd0,
    EXC_FAULT_FETCH      = 4'd1,
    EXC_MISALIGNED_LOAD  = 4'd4,
    EXC_FAULT_LOAD       = 4'd5,
    EXC_MISALIGNED_STORE = 4'd6,
    EXC_FAULT_STORE      = 4'd7
  } exc_cause_e;

endpackage

// ==== logic/csr_types_pkg.sv ====
/*
  datapath types shared by the CSR file blocks
  exc_info_t uses the cause enum of csr_map_pkg, compile that package first
*/
`include "csr_consts.svh"

package csr_types_pkg;

  typedef logic [`CSR_WIDTH-1:0]        csr_data_t;
  typedef logic [`CSR_ADDR_WIDTH-1:0]   csr_addr_t;
  typedef logic [`CSR_WIDTH-1:0]        vaddr_t;
  typedef logic [`COMMIT_CNT_WIDTH-1:0] commit_cnt_t;

  // committed CSR write, 77 bits
  typedef struct packed {
    logic      valid;
    csr_addr_t addr;
    csr_data_t data;
  } csr_commit_wr_t;

  // exception reported by retire, 197 bits
  typedef struct packed {
    logic                   valid;
    csr_map_pkg::exc_cause_e cause;
    vaddr_t                 pc;
    vaddr_t                 ld_addr;
    vaddr_t                 st_addr;
  } exc_info_t;

  // registers owned by the trap group
  typedef struct packed {
    csr_data_t epc;
    csr_data_t badvaddr;
    csr_data_t evec;
    csr_data_t cause;
    csr_data_t status;
  } trap_view_t;

  // registers owned by the fp and counter group
  typedef struct packed {
    csr_data_t fcsr;
    csr_data_t count;
    csr_data_t sup0;
    csr_data_t sup1;
  } fp_count_view_t;

endpackage

// ==== logic/csr_write_stage.sv ====
/*
  holds one CSR write until its instruction commits
  only one write may be in flight, a new reg_wr_en_i overwrites the held one
*/
module csr_write_stage (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        flush_i,
  input  logic                        reg_wr_en_i,
  input  logic                        commit_reg_i,
  input  csr_types_pkg::csr_addr_t    reg_wr_addr_i,
  input  csr_types_pkg::csr_data_t    reg_wr_data_i,
  output csr_types_pkg::csr_commit_wr_t commit_wr_o
);

  csr_types_pkg::csr_addr_t wr_addr_q;
  csr_types_pkg::csr_data_t wr_data_q;
  logic                     wr_pend_q;

  // payload of the write in flight
  always_ff @(posedge clk)
  begin
    if (reg_wr_en_i)
    begin
      wr_addr_q <= reg_wr_addr_i;
      wr_data_q <= reg_wr_data_i;
    end
  end

  // pending flag, a new write beats a flush in the same cycle
  // stays set across commits so a repeated commit rewrites the same value
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_pend_q <= 1'b0;
    end
    else if (reg_wr_en_i)
    begin
      wr_pend_q <= 1'b1;
    end
    else if (flush_i)
    begin
      wr_pend_q <= 1'b0;
    end
  end

  assign commit_wr_o.valid = commit_reg_i & wr_pend_q;
  assign commit_wr_o.addr  = wr_addr_q;
  assign commit_wr_o.data  = wr_data_q;

endmodule

// ==== logic/csr_trap_regs.sv ====
/*
  epc, cause, badvaddr, evec and status with exception capture and sret
  a committed write to a register beats the exception or sret update of that cycle
  status keeps only the bits of CSR_STATUS_WR_MASK
*/
`include "csr_consts.svh"

module csr_trap_regs (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          sret_flag_i,
  input  csr_types_pkg::csr_commit_wr_t commit_wr_i,
  input  csr_types_pkg::exc_info_t      exc_i,
  output csr_types_pkg::trap_view_t     trap_o
);

  csr_types_pkg::trap_view_t regs_q;
  csr_types_pkg::trap_view_t regs_d;

  logic wr_epc;
  logic wr_badvaddr;
  logic wr_evec;
  logic wr_cause;
  logic wr_status;

  // address decode against this group only
  assign wr_epc      = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_EPC);
  assign wr_badvaddr = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_BADVADDR);
  assign wr_evec     = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_EVEC);
  assign wr_cause    = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_CAUSE);
  assign wr_status   = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_STATUS);

  always_comb
  begin
    regs_d = regs_q;

    // exception capture
    if (exc_i.valid)
    begin
      regs_d.epc   = exc_i.pc;
      regs_d.cause = {{(`CSR_WIDTH-`CAUSE_WIDTH){1'b0}}, exc_i.cause};
      // faulting address picked by cause, other causes keep badvaddr
      case (exc_i.cause)
        csr_map_pkg::EXC_MISALIGNED_FETCH,
        csr_map_pkg::EXC_FAULT_FETCH:      regs_d.badvaddr = exc_i.pc;
        csr_map_pkg::EXC_MISALIGNED_LOAD,
        csr_map_pkg::EXC_FAULT_LOAD:       regs_d.badvaddr = exc_i.ld_addr;
        csr_map_pkg::EXC_MISALIGNED_STORE,
        csr_map_pkg::EXC_FAULT_STORE:      regs_d.badvaddr = exc_i.st_addr;
        default:                           regs_d.badvaddr = regs_q.badvaddr;
      endcase
    end

    // supervisor return restores S and EI from their saved copies
    if (sret_flag_i)
    begin
      regs_d.status[`SR_S_BIT]  = regs_q.status[`SR_PS_BIT];
      regs_d.status[`SR_EI_BIT] = regs_q.status[`SR_PEI_BIT];
    end

    // committed writes win
    if (wr_epc)
    begin
      regs_d.epc = commit_wr_i.data;
    end
    if (wr_badvaddr)
    begin
      regs_d.badvaddr = commit_wr_i.data;
    end
    if (wr_evec)
    begin
      regs_d.evec = commit_wr_i.data;
    end
    if (wr_cause)
    begin
      regs_d.cause = commit_wr_i.data;
    end
    if (wr_status)
    begin
      regs_d.status = commit_wr_i.data & `CSR_STATUS_WR_MASK;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      regs_q.epc      <= '0;
      regs_q.badvaddr <= '0;
      regs_q.evec     <= '0;
      regs_q.cause    <= '0;
      regs_q.status   <= `CSR_STATUS_RESET;
    end
    else
    begin
      regs_q <= regs_d;
    end
  end

  assign trap_o = regs_q;

endmodule

// ==== logic/csr_fp_count_regs.sv ====
/*
  fcsr with flag accumulation, the commit counter and two scratch registers
  fcsr holds only its low FCSR_WIDTH bits, upper bits stay zero
  count wraps at 2^64
*/
`include "csr_consts.svh"

module csr_fp_count_regs (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          exception_flag_i,
  input  csr_types_pkg::csr_commit_wr_t commit_wr_i,
  input  csr_types_pkg::commit_cnt_t    total_commit_i,
  input  csr_types_pkg::csr_data_t      fflags_i,
  output csr_types_pkg::fp_count_view_t fpc_o
);

  csr_types_pkg::fp_count_view_t regs_q;
  csr_types_pkg::fp_count_view_t regs_d;

  logic wr_fflags;
  logic wr_frm;
  logic wr_fcsr;
  logic wr_count;
  logic wr_sup0;
  logic wr_sup1;

  assign wr_fflags = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_FFLAGS);
  assign wr_frm    = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_FRM);
  assign wr_fcsr   = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_FCSR);
  assign wr_count  = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_COUNT);
  assign wr_sup0   = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_SUP0);
  assign wr_sup1   = commit_wr_i.valid && (commit_wr_i.addr == csr_map_pkg::CSR_SUP1);

  always_comb
  begin
    regs_d = regs_q;

    // one rule per cycle for fcsr, a field write replaces, else flags accumulate
    if (wr_fcsr)
    begin
      regs_d.fcsr[`FCSR_WIDTH-1:0] = commit_wr_i.data[`FCSR_WIDTH-1:0];
    end
    else if (wr_frm)
    begin
      regs_d.fcsr[`FCSR_WIDTH-1:`FRM_LSB] = commit_wr_i.data[`FCSR_WIDTH-`FRM_LSB-1:0];
    end
    else if (wr_fflags)
    begin
      regs_d.fcsr[`FFLAGS_WIDTH-1:0] = commit_wr_i.data[`FFLAGS_WIDTH-1:0];
    end
    else
    begin
      regs_d.fcsr[`FFLAGS_WIDTH-1:0] = regs_q.fcsr[`FFLAGS_WIDTH-1:0] |
                                       fflags_i[`FFLAGS_WIDTH-1:0];
    end

    // retired instructions plus exceptions, unless software writes count
    if (wr_count)
    begin
      regs_d.count = commit_wr_i.data;
    end
    else
    begin
      regs_d.count = regs_q.count + csr_types_pkg::csr_data_t'(total_commit_i) +
                     csr_types_pkg::csr_data_t'(exception_flag_i);
    end

    if (wr_sup0)
    begin
      regs_d.sup0 = commit_wr_i.data;
    end
    if (wr_sup1)
    begin
      regs_d.sup1 = commit_wr_i.data;
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      regs_q <= '0;
    end
    else
    begin
      regs_q <= regs_d;
    end
  end

  assign fpc_o = regs_q;

endmodule

// ==== logic/csr_read_port.sv ====
/*
  combinational read port and the atomic read check
  the checkpoint remembers one read, a new read replaces it
  unmapped addresses read zero and never flag a violation
*/
`include "csr_consts.svh"

module csr_read_port (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          flush_i,
  input  logic                          commit_reg_i,
  input  logic                          reg_rd_en_i,
  input  csr_types_pkg::csr_addr_t      reg_rd_addr_i,
  input  csr_types_pkg::trap_view_t     trap_i,
  input  csr_types_pkg::fp_count_view_t fpc_i,
  output csr_types_pkg::csr_data_t      reg_rd_data_o,
  output logic                          atomic_rd_vio_o
);

  csr_types_pkg::csr_addr_t chk_addr_q;
  csr_types_pkg::csr_data_t chk_data_q;
  logic                     chk_valid_q;

  // address to value, fp fields come back zero extended
  function automatic csr_types_pkg::csr_data_t csr_lookup(
    input csr_types_pkg::csr_addr_t      addr,
    input csr_types_pkg::trap_view_t     trap,
    input csr_types_pkg::fp_count_view_t fpc
  );
    csr_types_pkg::csr_data_t val;
    val = '0;
    case (addr)
      csr_map_pkg::CSR_FFLAGS:   val[`FFLAGS_WIDTH-1:0] = fpc.fcsr[`FFLAGS_WIDTH-1:0];
      csr_map_pkg::CSR_FRM:      val[`FCSR_WIDTH-`FRM_LSB-1:0] =
                                   fpc.fcsr[`FCSR_WIDTH-1:`FRM_LSB];
      csr_map_pkg::CSR_FCSR:     val[`FCSR_WIDTH-1:0] = fpc.fcsr[`FCSR_WIDTH-1:0];
      csr_map_pkg::CSR_EVEC:     val = trap.evec;
      csr_map_pkg::CSR_SUP0:     val = fpc.sup0;
      csr_map_pkg::CSR_SUP1:     val = fpc.sup1;
      csr_map_pkg::CSR_EPC:      val = trap.epc;
      csr_map_pkg::CSR_BADVADDR: val = trap.badvaddr;
      csr_map_pkg::CSR_COUNT:    val = fpc.count;
      csr_map_pkg::CSR_CAUSE:    val = trap.cause;
      csr_map_pkg::CSR_STATUS:   val = trap.status;
      default:                   val = '0;
    endcase
    return val;
  endfunction

  // live read, zero latency
  assign reg_rd_data_o = csr_lookup(reg_rd_addr_i, trap_i, fpc_i);

  // checkpoint payload, only meaningful while chk_valid_q is set
  always_ff @(posedge clk)
  begin
    if (reg_rd_en_i)
    begin
      chk_addr_q <= reg_rd_addr_i;
      chk_data_q <= reg_rd_data_o;
    end
  end

  // a read in the same cycle beats flush or commit
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      chk_valid_q <= 1'b0;
    end
    else if (reg_rd_en_i)
    begin
      chk_valid_q <= 1'b1;
    end
    else if (flush_i || commit_reg_i)
    begin
      chk_valid_q <= 1'b0;
    end
  end

  // value moved since it was read
  assign atomic_rd_vio_o = chk_valid_q &&
                           (csr_lookup(chk_addr_q, trap_i, fpc_i) != chk_data_q);

endmodule

// ==== logic/csr_file.sv ====
/*
  supervisor CSR file top, writes take effect when commit_reg_i sees a pending write
  reads are combinational, atomic_rd_vio_o asks retire to replay the CSR read
*/
`include "csr_consts.svh"

module csr_file (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       flush_i,
  input  csr_types_pkg::csr_addr_t   reg_wr_addr_i,
  input  csr_types_pkg::csr_data_t   reg_wr_data_i,
  input  logic                       reg_wr_en_i,
  input  logic                       commit_reg_i,
  input  csr_types_pkg::csr_addr_t   reg_rd_addr_i,
  input  logic                       reg_rd_en_i,
  output csr_types_pkg::csr_data_t   reg_rd_data_o,
  input  csr_types_pkg::commit_cnt_t total_commit_i,
  input  logic                       exception_flag_i,
  input  csr_types_pkg::vaddr_t      exception_pc_i,
  input  logic [`CAUSE_WIDTH-1:0]    exception_cause_i,
  input  csr_types_pkg::vaddr_t      st_commit_addr_i,
  input  csr_types_pkg::vaddr_t      ld_commit_addr_i,
  input  logic                       sret_flag_i,
  input  csr_types_pkg::csr_data_t   fflags_i,
  output logic                       atomic_rd_vio_o,
  output csr_types_pkg::csr_data_t   epc_o,
  output csr_types_pkg::csr_data_t   evec_o,
  output csr_types_pkg::csr_data_t   status_o,
  output csr_types_pkg::csr_data_t   frm_o
);

  csr_types_pkg::csr_commit_wr_t commit_wr;
  csr_types_pkg::exc_info_t      exc;
  csr_types_pkg::trap_view_t     trap;
  csr_types_pkg::fp_count_view_t fpc;

  // exception bundle for the trap group
  assign exc.valid   = exception_flag_i;
  assign exc.cause   = csr_map_pkg::exc_cause_e'(exception_cause_i);
  assign exc.pc      = exception_pc_i;
  assign exc.ld_addr = ld_commit_addr_i;
  assign exc.st_addr = st_commit_addr_i;

  csr_write_stage u_write_stage (
    .clk           (clk),
    .reset         (reset),
    .flush_i       (flush_i),
    .reg_wr_en_i   (reg_wr_en_i),
    .commit_reg_i  (commit_reg_i),
    .reg_wr_addr_i (reg_wr_addr_i),
    .reg_wr_data_i (reg_wr_data_i),
    .commit_wr_o   (commit_wr)
  );

  csr_trap_regs u_trap_regs (
    .clk         (clk),
    .reset       (reset),
    .sret_flag_i (sret_flag_i),
    .commit_wr_i (commit_wr),
    .exc_i       (exc),
    .trap_o      (trap)
  );

  csr_fp_count_regs u_fp_count_regs (
    .clk              (clk),
    .reset            (reset),
    .exception_flag_i (exception_flag_i),
    .commit_wr_i      (commit_wr),
    .total_commit_i   (total_commit_i),
    .fflags_i         (fflags_i),
    .fpc_o            (fpc)
  );

  csr_read_port u_read_port (
    .clk             (clk),
    .reset           (reset),
    .flush_i         (flush_i),
    .commit_reg_i    (commit_reg_i),
    .reg_rd_en_i     (reg_rd_en_i),
    .reg_rd_addr_i   (reg_rd_addr_i),
    .trap_i          (trap),
    .fpc_i           (fpc),
    .reg_rd_data_o   (reg_rd_data_o),
    .atomic_rd_vio_o (atomic_rd_vio_o)
  );

  assign epc_o    = trap.epc;
  assign evec_o   = trap.evec;
  assign status_o = trap.status;
  // rounding mode field, zero extended
  assign frm_o    = {{(`CSR_WIDTH-`FCSR_WIDTH+`FRM_LSB){1'b0}},
                     fpc.fcsr[`FCSR_WIDTH-1:`FRM_LSB]};

endmodule

// ==== dv/csr_file_checker.sv ====
/*
  assertions bound onto csr_file, sampled on the rising clock
  covers the reset state of the atomic read flag, epc update sources and status mask
*/
`include "csr_consts.svh"

module csr_file_checker (
  input logic                     clk,
  input logic                     reset,
  input logic                     exc_flag_i,
  input logic                     commit_i,
  input logic                     vio_i,
  input csr_types_pkg::csr_data_t epc_i,
  input csr_types_pkg::csr_data_t status_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // no checkpoint survives reset
  vio_low_after_reset: assert property (@(posedge clk) $fell(reset) |-> !vio_i)
    else $error("atomic_rd_vio_o high in the first cycle after reset");

  // epc moves only on an exception or a committed write
  epc_source: assert property (@(posedge clk) disable iff (reset)
    $changed(epc_i) |-> $past(exc_flag_i || commit_i))
    else $error("epc_o changed without an exception or commit");

  // unimplemented status bits read zero
  status_masked: assert property (@(posedge clk) disable iff (reset)
    (status_i & ~`CSR_STATUS_WR_MASK) == '0)
    else $error("status_o has bits outside the writable mask");

endmodule

bind csr_file csr_file_checker u_checker (
  .clk        (clk),
  .reset      (reset),
  .exc_flag_i (exception_flag_i),
  .commit_i   (commit_reg_i),
  .vio_i      (atomic_rd_vio_o),
  .epc_i      (epc_o),
  .status_i   (status_o)
);

// ==== dv/csr_file_tb.sv ====
/*
  table driven testbench for the supervisor CSR file
  expected values follow the CSR rules, random data comes from a fixed seed
*/
`include "csr_consts.svh"

module csr_file_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // cycles allowed for the atomic read flag to react
  localparam int VIO_WAIT = 8;
  // load and store addresses sit at fixed offsets from the exception pc
  localparam logic [63:0] LD_OFS = 64'h40;
  localparam logic [63:0] ST_OFS = 64'h80;

  typedef enum logic [2:0] {
    OP_WR_COMMIT, OP_WR_FLUSH, OP_EXC, OP_SRET, OP_COUNT, OP_FLAGS, OP_READ, OP_VIO
  } op_e;

  // which DUT output a test compares
  typedef enum logic [2:0] {
    OUT_RD, OUT_EPC, OUT_EVEC, OUT_STATUS, OUT_FRM, OUT_VIO
  } out_e;

  typedef struct {
    string                    name;
    op_e                      kind;
    csr_types_pkg::csr_addr_t addr;
    csr_types_pkg::csr_data_t data;
    logic [3:0]               cause;
    logic [7:0]               cycles;
    out_e                     port;
    csr_types_pkg::csr_addr_t rd_addr;
    csr_types_pkg::csr_data_t expected;
  } test_t;

  logic                        clk;
  logic                        reset;
  logic                        flush;
  csr_types_pkg::csr_addr_t    wr_addr;
  csr_types_pkg::csr_data_t    wr_data;
  logic                        wr_en;
  logic                        commit;
  csr_types_pkg::csr_addr_t    rd_addr;
  logic                        rd_en;
  csr_types_pkg::csr_data_t    rd_data;
  csr_types_pkg::commit_cnt_t  total_commit;
  logic                        exc_flag;
  csr_types_pkg::vaddr_t       exc_pc;
  logic [`CAUSE_WIDTH-1:0]     exc_cause;
  csr_types_pkg::vaddr_t       st_addr;
  csr_types_pkg::vaddr_t       ld_addr;
  logic                        sret;
  csr_types_pkg::csr_data_t    fflags;
  logic                        vio;
  csr_types_pkg::csr_data_t    epc;
  csr_types_pkg::csr_data_t    evec;
  csr_types_pkg::csr_data_t    status;
  csr_types_pkg::csr_data_t    frm;

  test_t tests[$];
  int    seed;
  int    n_pass;
  int    n_fail;

  csr_file DUT (
    .clk               (clk),
    .reset             (reset),
    .flush_i           (flush),
    .reg_wr_addr_i     (wr_addr),
    .reg_wr_data_i     (wr_data),
    .reg_wr_en_i       (wr_en),
    .commit_reg_i      (commit),
    .reg_rd_addr_i     (rd_addr),
    .reg_rd_en_i       (rd_en),
    .reg_rd_data_o     (rd_data),
    .total_commit_i    (total_commit),
    .exception_flag_i  (exc_flag),
    .exception_pc_i    (exc_pc),
    .exception_cause_i (exc_cause),
    .st_commit_addr_i  (st_addr),
    .ld_commit_addr_i  (ld_addr),
    .sret_flag_i       (sret),
    .fflags_i          (fflags),
    .atomic_rd_vio_o   (vio),
    .epc_o             (epc),
    .evec_o            (evec),
    .status_o          (status),
    .frm_o             (frm)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic csr_types_pkg::csr_data_t rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic void add_test(input string name, input op_e kind,
                                   input csr_types_pkg::csr_addr_t addr,
                                   input csr_types_pkg::csr_data_t data,
                                   input logic [3:0] cause, input logic [7:0] cycles,
                                   input out_e port, input csr_types_pkg::csr_addr_t rd_a,
                                   input csr_types_pkg::csr_data_t expected);
    test_t t;
    t = '{name, kind, addr, data, cause, cycles, port, rd_a, expected};
    tests.push_back(t);
  endfunction

  task automatic build_table();
    csr_types_pkg::csr_data_t d;
    csr_types_pkg::csr_data_t bad;
    logic [3:0]               causes [6];
    // cause 0 last so every cause read differs from the value before it
    causes = '{4'd7, 4'd6, 4'd5, 4'd4, 4'd1, 4'd0};
    // write, commit, read back
    d = rand64();
    add_test("sup0 write", OP_WR_COMMIT, csr_map_pkg::CSR_SUP0, d, '0, '0,
             OUT_RD, csr_map_pkg::CSR_SUP0, d);
    d = rand64();
    add_test("epc write", OP_WR_COMMIT, csr_map_pkg::CSR_EPC, d, '0, '0,
             OUT_RD, csr_map_pkg::CSR_EPC, d);
    add_test("epc port", OP_READ, '0, '0, '0, '0, OUT_EPC, '0, d);
    d = rand64();
    add_test("evec write", OP_WR_COMMIT, csr_map_pkg::CSR_EVEC, d, '0, '0,
             OUT_RD, csr_map_pkg::CSR_EVEC, d);
    add_test("evec port", OP_READ, '0, '0, '0, '0, OUT_EVEC, '0, d);
    // a flushed write never lands
    d = rand64();
    add_test("sup1 write", OP_WR_COMMIT, csr_map_pkg::CSR_SUP1, d, '0, '0,
             OUT_RD, csr_map_pkg::CSR_SUP1, d);
    add_test("sup1 flushed", OP_WR_FLUSH, csr_map_pkg::CSR_SUP1, rand64(), '0, '0,
             OUT_RD, csr_map_pkg::CSR_SUP1, d);
    // fetch causes report pc, load causes the load address, store causes the store address
    bad = '0;
    for (int i = 0; i < 6; i++)
    begin
      d = rand64();
      if (causes[i] < 4'd4)
        bad = d;
      else if (causes[i] < 4'd6)
        bad = d + LD_OFS;
      else
        bad = d + ST_OFS;
      add_test($sformatf("exc %0d epc", causes[i]), OP_EXC, '0, d, causes[i], '0,
               OUT_EPC, '0, d);
      add_test($sformatf("exc %0d cause", causes[i]), OP_READ, '0, '0, '0, '0,
               OUT_RD, csr_map_pkg::CSR_CAUSE, {60'b0, causes[i]});
      add_test($sformatf("exc %0d badvaddr", causes[i]), OP_READ, '0, '0, '0, '0,
               OUT_RD, csr_map_pkg::CSR_BADVADDR, bad);
    end
    add_test("exc unlisted", OP_EXC, '0, rand64(), 4'd9, '0,
             OUT_RD, csr_map_pkg::CSR_BADVADDR, bad);
    // counter steps by k for n cycles
    add_test("count write", OP_WR_COMMIT, csr_map_pkg::CSR_COUNT, 64'd1000, '0, '0,
             OUT_RD, csr_map_pkg::CSR_COUNT, 64'd1000);
    add_test("count step", OP_COUNT, '0, 64'd5, '0, 8'd7,
             OUT_RD, csr_map_pkg::CSR_COUNT, 64'd1000 + 64'd7 * 64'd5);
    d = rand64();
    // low bit set so the rounding mode leaves its reset value
    d[0] = 1'b1;
    add_test("frm write", OP_WR_COMMIT, csr_map_pkg::CSR_FRM, d, '0, '0,
             OUT_FRM, '0, {61'b0, d[2:0]});
    add_test("fflags write", OP_WR_COMMIT, csr_map_pkg::CSR_FFLAGS, 64'h05, '0, '0,
             OUT_RD, csr_map_pkg::CSR_FFLAGS, 64'h05);
    add_test("fflags accrue", OP_FLAGS, '0, 64'h12, '0, '0,
             OUT_RD, csr_map_pkg::CSR_FFLAGS, 64'h05 | 64'h12);
    // status keeps only writable bits, sret moves PS to S and PEI to EI
    add_test("status mask", OP_WR_COMMIT, csr_map_pkg::CSR_STATUS, '1, '0, '0,
             OUT_RD, csr_map_pkg::CSR_STATUS, `CSR_STATUS_WR_MASK);
    // S set with PS clear, so sret has to drop S
    add_test("status pei", OP_WR_COMMIT, csr_map_pkg::CSR_STATUS, 64'h9, '0, '0,
             OUT_STATUS, '0, 64'h9);
    add_test("sret", OP_SRET, '0, '0, '0, '0, OUT_STATUS, '0, 64'hc);
    // atomic read check
    add_test("vio count", OP_VIO, csr_map_pkg::CSR_COUNT, 64'd3, '0, '0, OUT_VIO, '0, 64'd1);
    add_test("vio sup0", OP_VIO, csr_map_pkg::CSR_SUP0, 64'd3, '0, '0, OUT_VIO, '0, 64'd0);
  endtask

  task automatic report(input test_t t, input csr_types_pkg::csr_data_t got);
    if (got !== t.expected)
    begin
      $display("ERR %s expected %h actual %h", t.name, t.expected, got);
      n_fail++;
    end
    else
    begin
      $display("ok  %s %h", t.name, got);
      n_pass++;
    end
  endtask

  // drop set means a flush lands between the write and its commit
  task automatic write_commit(input csr_types_pkg::csr_addr_t a,
                              input csr_types_pkg::csr_data_t d, input logic drop);
    @(posedge clk);
    wr_en   <= 1'b1;
    wr_addr <= a;
    wr_data <= d;
    @(posedge clk);
    wr_en <= 1'b0;
    if (drop)
    begin
      flush <= 1'b1;
      @(posedge clk);
      flush <= 1'b0;
    end
    commit <= 1'b1;
    @(posedge clk);
    commit <= 1'b0;
  endtask

  task automatic raise_exception(input logic [3:0] cause, input csr_types_pkg::vaddr_t pc);
    @(posedge clk);
    exc_flag  <= 1'b1;
    exc_cause <= cause;
    exc_pc    <= pc;
    ld_addr   <= pc + LD_OFS;
    st_addr   <= pc + ST_OFS;
    @(posedge clk);
    exc_flag <= 1'b0;
  endtask

  task automatic step_count(input csr_types_pkg::commit_cnt_t k, input logic [7:0] n);
    @(posedge clk);
    total_commit <= k;
    repeat (n) @(posedge clk);
    total_commit <= '0;
  endtask

  task automatic pulse_sret();
    @(posedge clk);
    sret <= 1'b1;
    @(posedge clk);
    sret <= 1'b0;
  endtask

  task automatic pulse_flags(input csr_types_pkg::csr_data_t bits);
    @(posedge clk);
    fflags <= bits;
    @(posedge clk);
    fflags <= '0;
  endtask

  // read under a moving counter, then commit to clear the checkpoint
  task automatic check_atomic(input test_t t);
    int   waited;
    logic seen;
    seen = 1'b0;
    @(posedge clk);
    rd_addr      <= t.addr;
    rd_en        <= 1'b1;
    total_commit <= t.data[2:0];
    @(posedge clk);
    rd_en        <= 1'b0;
    total_commit <= '0;
    @(negedge clk);
    if (t.expected[0])
    begin
      waited = 0;
      while (vio !== 1'b1 && waited < VIO_WAIT)
      begin
        @(negedge clk);
        waited++;
      end
      if (vio !== 1'b1)
      begin
        $display("timeout waiting for atomic_rd_vio_o to rise in %s", t.name);
        n_fail++;
        return;
      end
      seen = 1'b1;
    end
    else
    begin
      repeat (VIO_WAIT)
      begin
        @(negedge clk);
        if (vio !== 1'b0)
          seen = 1'b1;
      end
    end
    @(posedge clk);
    commit <= 1'b1;
    @(posedge clk);
    commit <= 1'b0;
    @(negedge clk);
    if (vio !== 1'b0)
    begin
      $display("ERR %s expected 0 actual %b after commit", t.name, vio);
      n_fail++;
      return;
    end
    report(t, {63'b0, seen});
  endtask

  task automatic run_test(input test_t t);
    csr_types_pkg::csr_data_t got;
    if (t.kind == OP_VIO)
    begin
      check_atomic(t);
      return;
    end
    case (t.kind)
      OP_WR_COMMIT: write_commit(t.addr, t.data, 1'b0);
      OP_WR_FLUSH:  write_commit(t.addr, t.data, 1'b1);
      OP_EXC:       raise_exception(t.cause, t.data);
      OP_SRET:      pulse_sret();
      OP_COUNT:     step_count(t.data[2:0], t.cycles);
      OP_FLAGS:     pulse_flags(t.data);
      default:      ;
    endcase
    @(posedge clk);
    rd_addr <= t.rd_addr;
    @(negedge clk);
    case (t.port)
      OUT_EPC:    got = epc;
      OUT_EVEC:   got = evec;
      OUT_STATUS: got = status;
      OUT_FRM:    got = frm;
      default:    got = rd_data;
    endcase
    report(t, got);
  endtask

  initial
  begin
    seed         = 32'hddf539c7;
    n_pass       = 0;
    n_fail       = 0;
    reset        = 1'b1;
    flush        = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    wr_en        = 1'b0;
    commit       = 1'b0;
    rd_addr      = '0;
    rd_en        = 1'b0;
    total_commit = '0;
    exc_flag     = 1'b0;
    exc_pc       = '0;
    exc_cause    = '0;
    st_addr      = '0;
    ld_addr      = '0;
    sret         = 1'b0;
    fflags       = '0;
    build_table();
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    foreach (tests[i])
      run_test(tests[i]);
    repeat (2) @(posedge clk);
    $display("tests %0d passed %0d failed %0d", tests.size(), n_pass, n_fail);
    if (n_fail == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

  // whole run bound, far above the table length
  initial
  begin
    #(2000 * 100);
    $display("simulation did not finish within its time limit");
    $display("=== FAIL ===");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+logic
logic/csr_map_pkg.sv
logic/csr_types_pkg.sv
logic/csr_write_stage.sv
logic/csr_trap_regs.sv
logic/csr_fp_count_regs.sv
logic/csr_read_port.sv
logic/csr_file.sv
dv/csr_file_checker.sv
dv/csr_file_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the CSR file testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f compile.f --top-module csr_file_tb -Mdir obj_dir -o csr_file_sim; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/csr_file_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "=== PASS ==="; then
  exit 0
fi
echo "simulation did not report success"
exit 1
